/* hw/laser_pkg.sv */
`default_nettype none

package laser_pkg;

  ////////////////////////////////////////////////////////////
  // Pixel and screen types
  ////////////////////////////////////////////////////////////

  // 4 bits each of red, green, blue
  typedef logic [11:0] pixel_t;

  typedef logic [11:0] coord_t;

  // Beam colour
  localparam pixel_t white_px = 12'hfff;

  ////////////////////////////////////////////////////////////
  // Beam and controller types
  ////////////////////////////////////////////////////////////

  // Rectangle being drawn, all edges inclusive
  typedef struct packed {
    coord_t left;
    coord_t right;
    coord_t top;
    coord_t bottom;
    logic   valid;
  } beam_t;

  typedef enum logic [1:0] {
    ph_idle,
    ph_widen,
    ph_pause,
    ph_hold
  } laser_phase_e;

  // Request to the interval timer
  typedef struct packed {
    logic req;
    logic sel;
  } timer_req_t;

  // Interval select codes
  localparam logic sel_step  = 1'b0;
  localparam logic sel_pause = 1'b1;

endpackage

`default_nettype wire

/* hw/raster_counter.sv */
`default_nettype none

module raster_counter #(
  parameter int H_ACTIVE = 800,
  parameter int H_TOTAL  = 1056,
  parameter int V_ACTIVE = 600,
  parameter int V_TOTAL  = 628
) (
  input  wire               pclk,
  input  wire               rst,
  output laser_pkg::coord_t hcount,
  output laser_pkg::coord_t vcount
);

  import laser_pkg::*;

  // Frame total always leaves at least one blanking pixel or line
  localparam int H_SPAN = (H_TOTAL > H_ACTIVE) ? H_TOTAL : H_ACTIVE + 1;
  localparam int V_SPAN = (V_TOTAL > V_ACTIVE) ? V_TOTAL : V_ACTIVE + 1;

  // Last count before wrapping
  localparam coord_t H_END = coord_t'(H_SPAN - 1);
  localparam coord_t V_END = coord_t'(V_SPAN - 1);

  logic line_end;
  logic frame_end;

  assign line_end  = (hcount == H_END);
  assign frame_end = (vcount == V_END);

  ////////////////////////////////////////////////////////////
  // Pixel and line counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
    end else if (line_end) begin
      hcount <= '0;
      // Next line, or back to the top of the frame
      if (frame_end) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 1'b1;
      end
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/beam_timer.sv */
`default_nettype none

module beam_timer #(
  parameter int STEP_TICKS  = 325000,
  parameter int PAUSE_TICKS = 325000
) (
  input  wire                   pclk,
  input  wire                   rst,
  input  wire laser_pkg::timer_req_t timer_req,
  output logic                  ack
);

  import laser_pkg::*;

  localparam int MAX_TICKS = (STEP_TICKS > PAUSE_TICKS) ? STEP_TICKS : PAUSE_TICKS;
  localparam int CW        = $clog2(MAX_TICKS + 1);

  // Count value on the last tick of each interval
  localparam logic [CW-1:0] STEP_LAST  = CW'(STEP_TICKS - 1);
  localparam logic [CW-1:0] PAUSE_LAST = CW'(PAUSE_TICKS - 1);

  logic [CW-1:0] count;
  logic [CW-1:0] last;

  // sel is held stable by the controller while req is up
  assign last = (timer_req.sel == sel_pause) ? PAUSE_LAST : STEP_LAST;

  ////////////////////////////////////////////////////////////
  // Tick counter and ack
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (rst) begin
      count <= '0;
      ack   <= 1'b0;
    end else if (!timer_req.req) begin
      // Request withdrawn, drop ack and start over
      count <= '0;
      ack   <= 1'b0;
    end else if (!ack) begin
      if (count == last) begin
        ack <= 1'b1;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/laser_ctrl.sv */
`default_nettype none

module laser_ctrl #(
  parameter int BEAM_CENTER   = 411,
  parameter int BEAM_TOP      = 317,
  parameter int BEAM_BOTTOM   = 587,
  parameter int BEAM_MAX_HALF = 25
) (
  input  wire                     pclk,
  input  wire                     rst,
  input  wire                     play_selected,
  input  wire                     game_on,
  input  wire                     menu_on,
  input  wire                     ack,
  output laser_pkg::timer_req_t   timer_req,
  output laser_pkg::beam_t        beam,
  output laser_pkg::laser_phase_e phase
);

  import laser_pkg::*;

  localparam coord_t CENTER   = coord_t'(BEAM_CENTER);
  localparam coord_t TOP      = coord_t'(BEAM_TOP);
  localparam coord_t BOTTOM   = coord_t'(BEAM_BOTTOM);
  localparam coord_t MAX_HALF = coord_t'(BEAM_MAX_HALF);

  laser_phase_e phase_nxt;
  timer_req_t   req_nxt;
  coord_t       left;
  coord_t       right;
  coord_t       left_nxt;
  coord_t       right_nxt;
  coord_t       half;
  coord_t       half_nxt;
  logic         valid;
  logic         valid_nxt;
  logic         abort;
  logic         req_done;
  logic         req_free;

  // Menu, or neither play nor a running game
  assign abort = menu_on || (!play_selected && !game_on);

  // Timer answered the current request
  assign req_done = timer_req.req && ack;
  // Both handshake lines low, a new request may start
  assign req_free = !timer_req.req && !ack;

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    phase_nxt = phase;
    req_nxt   = timer_req;
    left_nxt  = left;
    right_nxt = right;
    half_nxt  = half;
    valid_nxt = valid;
    if (abort) begin
      phase_nxt   = ph_idle;
      req_nxt.req = 1'b0;
      valid_nxt   = 1'b0;
    end else begin
      case (phase)
        ph_idle: begin
          // Not aborting means play or game is up
          phase_nxt = ph_widen;
          left_nxt  = CENTER;
          right_nxt = CENTER;
          half_nxt  = '0;
          valid_nxt = 1'b1;
        end
        ph_widen: begin
          if (req_done) begin
            req_nxt.req = 1'b0;
            left_nxt    = left - 1'b1;
            right_nxt   = right + 1'b1;
            half_nxt    = half + 1'b1;
            if (half_nxt == MAX_HALF) begin
              phase_nxt = ph_pause;
            end
          end else if (req_free) begin
            // Only taken directly when the full width is zero
            if (half == MAX_HALF) begin
              phase_nxt = ph_pause;
            end else begin
              req_nxt = '{req: 1'b1, sel: sel_step};
            end
          end
        end
        ph_pause: begin
          if (req_done) begin
            req_nxt.req = 1'b0;
            phase_nxt   = ph_hold;
          end else if (req_free) begin
            req_nxt = '{req: 1'b1, sel: sel_pause};
          end
        end
        // Full width beam stays until abort
        ph_hold:  phase_nxt = ph_hold;
        default:  phase_nxt = ph_idle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // State registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (rst) begin
      phase     <= ph_idle;
      timer_req <= '0;
      half      <= '0;
      valid     <= 1'b0;
    end else begin
      phase     <= phase_nxt;
      timer_req <= req_nxt;
      half      <= half_nxt;
      valid     <= valid_nxt;
    end
  end

  // Beam edges
  always_ff @(posedge pclk) begin
    left  <= left_nxt;
    right <= right_nxt;
  end

  assign beam = '{left: left, right: right, top: TOP, bottom: BOTTOM, valid: valid};

endmodule

`default_nettype wire

/* hw/beam_overlay.sv */
`default_nettype none

module beam_overlay (
  input  wire                    pclk,
  input  wire                    rst,
  input  wire laser_pkg::coord_t hcount,
  input  wire laser_pkg::coord_t vcount,
  input  wire laser_pkg::pixel_t rgb_in,
  input  wire laser_pkg::beam_t  beam,
  output laser_pkg::pixel_t      rgb_out
);

  import laser_pkg::*;

  logic   in_cols;
  logic   in_rows;
  logic   in_beam;
  pixel_t rgb_nxt;

  ////////////////////////////////////////////////////////////
  // Beam hit test
  ////////////////////////////////////////////////////////////

  // Edges inclusive on all four sides
  assign in_cols = (hcount >= beam.left) && (hcount <= beam.right);
  assign in_rows = (vcount >= beam.top) && (vcount <= beam.bottom);
  assign in_beam = beam.valid && in_cols && in_rows;

  assign rgb_nxt = in_beam ? white_px : rgb_in;

  // One cycle behind the counts
  always_ff @(posedge pclk) begin
    if (rst) begin
      rgb_out <= '0;
    end else begin
      rgb_out <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

/* hw/laser_stage.sv */
`default_nettype none

module laser_stage #(
  parameter int H_ACTIVE      = 800,
  parameter int H_TOTAL       = 1056,
  parameter int V_ACTIVE      = 600,
  parameter int V_TOTAL       = 628,
  parameter int STEP_TICKS    = 325000,
  parameter int PAUSE_TICKS   = 325000,
  parameter int BEAM_CENTER   = 411,
  parameter int BEAM_TOP      = 317,
  parameter int BEAM_BOTTOM   = 587,
  parameter int BEAM_MAX_HALF = 25
) (
  input  wire                     pclk,
  input  wire                     rst,
  input  wire                     play_selected,
  input  wire                     game_on,
  input  wire                     menu_on,
  input  wire laser_pkg::pixel_t  rgb_in,
  output laser_pkg::pixel_t       rgb_out,
  output laser_pkg::coord_t       hcount,
  output laser_pkg::coord_t       vcount,
  output laser_pkg::beam_t        beam,
  output laser_pkg::laser_phase_e phase
);

  import laser_pkg::*;

  // Controller to timer handshake
  timer_req_t timer_req;
  logic       ack;

  raster_counter #(
    .H_ACTIVE (H_ACTIVE),
    .H_TOTAL  (H_TOTAL),
    .V_ACTIVE (V_ACTIVE),
    .V_TOTAL  (V_TOTAL)
  ) u_raster_counter (
    .pclk   (pclk),
    .rst    (rst),
    .hcount (hcount),
    .vcount (vcount)
  );

  laser_ctrl #(
    .BEAM_CENTER   (BEAM_CENTER),
    .BEAM_TOP      (BEAM_TOP),
    .BEAM_BOTTOM   (BEAM_BOTTOM),
    .BEAM_MAX_HALF (BEAM_MAX_HALF)
  ) u_laser_ctrl (
    .pclk          (pclk),
    .rst           (rst),
    .play_selected (play_selected),
    .game_on       (game_on),
    .menu_on       (menu_on),
    .ack           (ack),
    .timer_req     (timer_req),
    .beam          (beam),
    .phase         (phase)
  );

  beam_timer #(
    .STEP_TICKS  (STEP_TICKS),
    .PAUSE_TICKS (PAUSE_TICKS)
  ) u_beam_timer (
    .pclk      (pclk),
    .rst       (rst),
    .timer_req (timer_req),
    .ack       (ack)
  );

  beam_overlay u_beam_overlay (
    .pclk    (pclk),
    .rst     (rst),
    .hcount  (hcount),
    .vcount  (vcount),
    .rgb_in  (rgb_in),
    .beam    (beam),
    .rgb_out (rgb_out)
  );

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic pclk,
  output logic rst
);

  initial begin
    pclk = 1'b0;
    forever #(PERIOD / 2) pclk = ~pclk;
  end

  // Release away from the rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge pclk);
    @(negedge pclk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* tests/laser_checker.sv */
`default_nettype none

module laser_checker #(
  parameter int H_TOTAL       = 40,
  parameter int V_TOTAL       = 30,
  parameter int BEAM_CENTER   = 20,
  parameter int BEAM_TOP      = 5,
  parameter int BEAM_BOTTOM   = 24,
  parameter int BEAM_MAX_HALF = 4
) (
  input  wire                          pclk,
  input  wire                          rst,
  input  wire laser_pkg::pixel_t       rgb_in,
  input  wire laser_pkg::pixel_t       rgb_out,
  input  wire laser_pkg::coord_t       hcount,
  input  wire laser_pkg::coord_t       vcount,
  input  wire laser_pkg::beam_t        beam,
  input  wire laser_pkg::laser_phase_e phase,
  input  wire                          done,
  output int                           pixel_errs,
  output int                           edge_errs,
  output int                           phase_errs
);

  import laser_pkg::*;

  int           exp_left_q[$];
  int           exp_right_q[$];
  laser_phase_e exp_phase_q[$];

  logic         prev_live;
  logic         leftovers_checked;
  int           raster_n;
  coord_t       prev_h;
  coord_t       prev_v;
  beam_t        prev_beam;
  pixel_t       prev_rgb;
  laser_phase_e prev_phase;

  ////////////////////////////////////////////////////////////
  // Expected edge and phase lists
  ////////////////////////////////////////////////////////////

  initial begin
    int                fd;
    int                n;
    int                l;
    int                r;
    logic [8*80-1:0]   line;
    logic [8*16-1:0]   word;
    logic [8*16-1:0]   name;
    fd = $fopen("tests/laser_golden.txt", "r");
    if (fd == 0) begin
      $display("Checker could not open tests/laser_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        word = '0;
        name = '0;
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%s", word);
          if (n == 1 && word == "edge") begin
            n = $sscanf(line, "%s %d %d", word, l, r);
            exp_left_q.push_back(l);
            exp_right_q.push_back(r);
          end else if (n == 1 && word == "phase") begin
            n = $sscanf(line, "%s %s", word, name);
            if (name == "idle") exp_phase_q.push_back(ph_idle);
            else if (name == "widen") exp_phase_q.push_back(ph_widen);
            else if (name == "pause") exp_phase_q.push_back(ph_pause);
            else exp_phase_q.push_back(ph_hold);
          end
        end
      end
      $fclose(fd);
    end
  end

  ////////////////////////////////////////////////////////////
  // Per-cycle comparison
  ////////////////////////////////////////////////////////////

  always @(posedge pclk) begin
    pixel_t exp_px;
    logic   hit;
    int     half;
    int     exp_h;
    int     exp_v;
    if (rst) begin
      pixel_errs        = 0;
      edge_errs         = 0;
      phase_errs        = 0;
      prev_live         = 1'b0;
      leftovers_checked = 1'b0;
      raster_n          = 0;
    end else begin
      // Raster position from the cycle count since reset
      exp_h = raster_n % H_TOTAL;
      exp_v = (raster_n / H_TOTAL) % V_TOTAL;
      if (int'(hcount) != exp_h || int'(vcount) != exp_v) begin
        pixel_errs++;
        $display("ERR %0t: raster at (%0d,%0d) expected (%0d,%0d)",
                 $time, hcount, vcount, exp_h, exp_v);
      end

      if (!prev_live) begin
        if (phase != ph_idle || beam.valid) begin
          phase_errs++;
          $display("ERR %0t: not idle with invalid beam after reset", $time);
        end
      end else begin
        // Output pixel from last cycle's counts and beam
        hit = prev_beam.valid && prev_h >= prev_beam.left && prev_h <= prev_beam.right
              && prev_v >= prev_beam.top && prev_v <= prev_beam.bottom;
        exp_px = hit ? white_px : prev_rgb;
        if (rgb_out !== exp_px) begin
          pixel_errs++;
          $display("ERR %0t: rgb_out %h expected %h at (%0d,%0d)",
                   $time, rgb_out, exp_px, prev_h, prev_v);
        end

        if (beam.valid && (!prev_beam.valid || beam.left != prev_beam.left
                           || beam.right != prev_beam.right)) begin
          if (!prev_beam.valid) begin
            if (beam.left != BEAM_CENTER || beam.right != BEAM_CENTER
                || beam.top != BEAM_TOP || beam.bottom != BEAM_BOTTOM) begin
              edge_errs++;
              $display("ERR %0t: new beam not at centre", $time);
            end
          end else begin
            if (beam.left != prev_beam.left - 1 || beam.right != prev_beam.right + 1) begin
              edge_errs++;
              $display("ERR %0t: beam step not one pixel outward", $time);
            end
            if (prev_phase == ph_hold) begin
              edge_errs++;
              $display("ERR %0t: beam edges changed in hold", $time);
            end
          end
          half = BEAM_CENTER - int'(beam.left);
          if (half > BEAM_MAX_HALF) begin
            edge_errs++;
            $display("ERR %0t: half-width %0d over maximum", $time, half);
          end
          if (exp_left_q.size() == 0) begin
            edge_errs++;
            $display("ERR %0t: unexpected beam edges %0d %0d", $time, beam.left, beam.right);
          end else begin
            if (int'(beam.left) != exp_left_q[0] || int'(beam.right) != exp_right_q[0]) begin
              edge_errs++;
              $display("ERR %0t: beam edges %0d %0d expected %0d %0d", $time,
                       beam.left, beam.right, exp_left_q[0], exp_right_q[0]);
            end
            void'(exp_left_q.pop_front());
            void'(exp_right_q.pop_front());
          end
        end

        if (phase != prev_phase) begin
          if (exp_phase_q.size() == 0) begin
            phase_errs++;
            $display("ERR %0t: unexpected phase %s", $time, phase.name());
          end else begin
            if (phase != exp_phase_q[0]) begin
              phase_errs++;
              $display("ERR %0t: phase %s expected %s", $time, phase.name(),
                       exp_phase_q[0].name());
            end
            void'(exp_phase_q.pop_front());
          end
          if (phase == ph_pause && BEAM_CENTER - int'(beam.left) != BEAM_MAX_HALF) begin
            phase_errs++;
            $display("ERR %0t: pause entered before full width", $time);
          end
        end
        if (phase == ph_idle && beam.valid) begin
          phase_errs++;
          $display("ERR %0t: beam valid while idle", $time);
        end
      end

      if (done && !leftovers_checked) begin
        leftovers_checked = 1'b1;
        if (exp_left_q.size() != 0) begin
          edge_errs += exp_left_q.size();
          $display("Beam edges never seen: %0d entries left", exp_left_q.size());
        end
        if (exp_phase_q.size() != 0) begin
          phase_errs += exp_phase_q.size();
          $display("Phases never seen: %0d entries left", exp_phase_q.size());
        end
      end

      prev_h     = hcount;
      prev_v     = vcount;
      prev_beam  = beam;
      prev_rgb   = rgb_in;
      prev_phase = phase;
      prev_live  = 1'b1;
      raster_n   = raster_n + 1;
    end
  end

endmodule

`default_nettype wire

/* tests/tb_laser_stage.sv */
`default_nettype none

module tb_laser_stage;

  import laser_pkg::*;

  localparam int H_TOTAL       = 40;
  localparam int V_TOTAL       = 30;
  localparam int STEP_TICKS    = 20;
  localparam int PAUSE_TICKS   = 30;
  localparam int BEAM_CENTER   = 20;
  localparam int BEAM_TOP      = 5;
  localparam int BEAM_BOTTOM   = 24;
  localparam int BEAM_MAX_HALF = 4;

  logic         pclk;
  logic         rst;
  logic         play_selected;
  logic         game_on;
  logic         menu_on;
  logic         done;
  pixel_t       rgb_in     = '0;
  int           rand_state = 98;
  int           cycles     = 0;
  int           limit;
  int           cmd_errs;
  pixel_t       rgb_out;
  coord_t       hcount;
  coord_t       vcount;
  beam_t        beam;
  laser_phase_e phase;
  int           pixel_errs;
  int           edge_errs;
  int           phase_errs;

  logic [8*16-1:0] op_q[$];
  int              arg_q[$];

  tb_clock #(.PERIOD(10), .RESET_CYCLES(3)) u_tb_clock (.pclk(pclk), .rst(rst));

  laser_stage #(
    .H_ACTIVE (32), .H_TOTAL (H_TOTAL), .V_ACTIVE (26), .V_TOTAL (V_TOTAL),
    .STEP_TICKS (STEP_TICKS), .PAUSE_TICKS (PAUSE_TICKS),
    .BEAM_CENTER (BEAM_CENTER), .BEAM_TOP (BEAM_TOP),
    .BEAM_BOTTOM (BEAM_BOTTOM), .BEAM_MAX_HALF (BEAM_MAX_HALF)
  ) u_laser_stage (
    .pclk (pclk), .rst (rst), .play_selected (play_selected), .game_on (game_on),
    .menu_on (menu_on), .rgb_in (rgb_in), .rgb_out (rgb_out), .hcount (hcount),
    .vcount (vcount), .beam (beam), .phase (phase)
  );

  laser_checker #(
    .H_TOTAL (H_TOTAL), .V_TOTAL (V_TOTAL),
    .BEAM_CENTER (BEAM_CENTER), .BEAM_TOP (BEAM_TOP),
    .BEAM_BOTTOM (BEAM_BOTTOM), .BEAM_MAX_HALF (BEAM_MAX_HALF)
  ) u_laser_checker (
    .pclk (pclk), .rst (rst), .rgb_in (rgb_in), .rgb_out (rgb_out), .hcount (hcount),
    .vcount (vcount), .beam (beam), .phase (phase), .done (done),
    .pixel_errs (pixel_errs), .edge_errs (edge_errs), .phase_errs (phase_errs)
  );

  function automatic int lcg_next(input int state);
    return state * 1103515245 + 12345;
  endfunction

  // New random picture pixel every falling edge
  always @(negedge pclk) begin
    rand_state = lcg_next(rand_state);
    rgb_in     = rand_state[27:16];
  end

  ////////////////////////////////////////////////////////////
  // Command list from the golden file
  ////////////////////////////////////////////////////////////

  task automatic load_commands();
    int              fd;
    int              n;
    int              val;
    logic [8*80-1:0] line;
    logic [8*16-1:0] word;
    fd = $fopen("tests/laser_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/laser_golden.txt");
      cmd_errs++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        word = '0;
        val  = 0;
        if ($fgets(line, fd) != 0) begin
          n = $sscanf(line, "%s %d", word, val);
          if (n == 2 && (word == "play" || word == "game" || word == "menu"
                         || word == "wait")) begin
            op_q.push_back(word);
            arg_q.push_back(val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_commands();
    for (int i = 0; i < op_q.size(); i++) begin
      if (op_q[i] == "play") play_selected = arg_q[i][0];
      else if (op_q[i] == "game") game_on = arg_q[i][0];
      else if (op_q[i] == "menu") menu_on = arg_q[i][0];
      else repeat (arg_q[i]) @(negedge pclk);
    end
  endtask

  initial begin
    play_selected = 1'b0;
    game_on       = 1'b0;
    menu_on       = 1'b0;
    done          = 1'b0;
    cmd_errs      = 0;
    load_commands();
    if (op_q.size() == 0) begin
      $display("Golden file holds no commands");
      cmd_errs++;
    end
    // Waits, full widening, pause, plus margin
    limit = 200 + BEAM_MAX_HALF * (STEP_TICKS + 4) + PAUSE_TICKS;
    foreach (op_q[i]) begin
      if (op_q[i] == "wait") limit += arg_q[i];
    end
    @(negedge rst);
    @(negedge pclk);
    run_commands();
    done = 1'b1;
    repeat (3) @(negedge pclk);
    $display("Errors: pixel %0d, edge %0d, phase %0d, command %0d",
             pixel_errs, edge_errs, phase_errs, cmd_errs);
    if (pixel_errs + edge_errs + phase_errs + cmd_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  always @(posedge pclk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: run went past %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sources.f */
hw/laser_pkg.sv
hw/raster_counter.sv
hw/beam_timer.sv
hw/laser_ctrl.sv
hw/beam_overlay.sv
hw/laser_stage.sv
tests/tb_clock.sv
tests/laser_checker.sv
tests/tb_laser_stage.sv

/* run.sh */
#!/bin/sh
# Build and run the laser_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -f sources.f --top-module tb_laser_stage \
  -Mdir "$BUILD" -o tb_laser_stage
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD/tb_laser_stage" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

if ! grep -q "PASS: all tests" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0

/* tests/laser_golden.txt */
# play|game|menu <0|1> sets an input, wait <n> runs n cycles
# edge <left> <right> and phase <name> list the expected changes in order
wait 50
play 1
wait 35
phase widen
edge 20 20
edge 19 21
menu 1
wait 10
phase idle
menu 0
wait 200
phase widen
edge 20 20
edge 19 21
edge 18 22
edge 17 23
edge 16 24
phase pause
phase hold
game 1
play 0
wait 20
game 0
wait 10
phase idle
play 1
wait 35
phase widen
edge 20 20
edge 19 21
play 0
wait 10
phase idle
